// ==== design/fma_align_add.sv ====
`timescale 1ns/1ps

module fma_align_add (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fma_fmt_pkg::prep_stage_t stage_i,
  input  logic                     valid_i,
  output fma_fmt_pkg::add_stage_t  stage_o,
  output logic                     valid_o
);
  import fma_fmt_pkg::*;

  sum_t               product_shifted;     // | 0..0 | product | RS |
  sum_t               addend_after_shift;
  mant_t              addend_sticky_bits;  // Bits shifted out the bottom
  sum_t               addend_shifted;
  logic               sticky_before_add;
  logic               inject_carry;
  logic [SUM_WIDTH:0] sum_raw;             // One extra bit for the carry
  logic               sum_carry;
  sum_t               sum;
  logic               final_sign;

  assign product_shifted = sum_t'(stage_i.product) << 2;

  // Addend starts above the whole window and moves right
  assign {addend_after_shift, addend_sticky_bits} =
      {stage_i.addend_mant, {SUM_WIDTH{1'b0}}} >> stage_i.addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;

  // Two's complement for subtraction, carry dropped when sticky bits were lost
  assign addend_shifted = stage_i.eff_sub ? ~addend_after_shift : addend_after_shift;
  assign inject_carry   = stage_i.eff_sub & ~sticky_before_add;

  assign sum_raw   = product_shifted + addend_shifted + inject_carry;
  assign sum_carry = sum_raw[SUM_WIDTH];

  // No carry on a subtraction means a negative sum
  assign sum = (stage_i.eff_sub && !sum_carry) ? sum_t'(-sum_raw) : sum_raw[SUM_WIDTH-1:0];
  assign final_sign = stage_i.eff_sub ? (sum_carry == stage_i.tentative_sign)  // Sign fix-up
                                      : stage_i.tentative_sign;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_o <= 1'b0;
    else          valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    stage_o <= '{sum: sum, final_sign: final_sign, sticky_before_add: sticky_before_add,
                 exp_difference: stage_i.exp_difference, exp_product: stage_i.exp_product,
                 tentative_exp: stage_i.tentative_exp, addend_shamt: stage_i.addend_shamt,
                 eff_sub: stage_i.eff_sub, rnd_mode: stage_i.rnd_mode,
                 special_result: stage_i.special_result,
                 special_status: stage_i.special_status, is_special: stage_i.is_special};
  end

endmodule

// ==== design/fma_classify.sv ====
`timescale 1ns/1ps

module fma_classify (
  input  fma_fmt_pkg::fp_word_t operand_i,
  output fma_fmt_pkg::fp_info_t info_o
);
  import fma_fmt_pkg::*;

  fp_t  value;
  logic exp_zero;   // Exponent field all zeros
  logic exp_ones;   // Exponent field all ones
  logic man_zero;
  logic is_nan;

  assign value    = operand_i;
  assign exp_zero = (value.exponent == '0);
  assign exp_ones = (value.exponent == '1);
  assign man_zero = (value.mantissa == '0);
  assign is_nan   = exp_ones && !man_zero;

  assign info_o.is_normal     = !exp_zero && !exp_ones;
  assign info_o.is_subnormal  = exp_zero && !man_zero;  // No implicit bit
  assign info_o.is_zero       = exp_zero && man_zero;
  assign info_o.is_inf        = exp_ones && man_zero;
  assign info_o.is_nan        = is_nan;
  // Quiet bit is the mantissa MSB
  assign info_o.is_signalling = is_nan && !value.mantissa[MAN_BITS-1];

endmodule

// ==== design/fma_fmt_pkg.sv ====
package fma_fmt_pkg;

  // ------------------------------
  // Binary16 format
  // ------------------------------
  localparam int EXP_BITS        = 5;
  localparam int MAN_BITS        = 10;
  localparam int BIAS            = 15;
  localparam int PRECISION_BITS  = MAN_BITS + 1;           // p, with implicit bit
  localparam int SUM_WIDTH       = 3 * PRECISION_BITS + 4; // Adder width, 37
  localparam int LOWER_SUM_WIDTH = 2 * PRECISION_BITS + 3; // LZC search window, 25
  localparam int LZC_WIDTH       = 5;
  localparam int EXP_WIDTH       = EXP_BITS + 2;           // Internal signed exponent
  localparam int SHAMT_WIDTH     = 6;                      // Covers shifts up to 3p+4

  typedef logic [EXP_BITS+MAN_BITS:0]  fp_word_t;
  typedef logic signed [EXP_WIDTH-1:0] exp_t;
  typedef logic [SHAMT_WIDTH-1:0]      shamt_t;
  typedef logic [PRECISION_BITS-1:0]   mant_t;
  typedef logic [SUM_WIDTH-1:0]        sum_t;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;  // NaN with quiet bit clear
  } fp_info_t;

  // ------------------------------
  // Pipeline payloads
  // ------------------------------
  // Stage 1 to 2
  typedef struct packed {
    logic [2*PRECISION_BITS-1:0] product;  // Raw mantissa product
    mant_t                  addend_mant;
    exp_t                   exp_product;
    exp_t                   exp_difference;   // Addend minus product
    exp_t                   tentative_exp;
    shamt_t                 addend_shamt;
    logic                   eff_sub;
    logic                   tentative_sign;   // Product sign
    fma_op_pkg::roundmode_e rnd_mode;
    fp_t                    special_result;
    fma_op_pkg::status_t    special_status;
    logic                   is_special;
  } prep_stage_t;

  // Stage 2 to 3
  typedef struct packed {
    sum_t                   sum;              // Magnitude of a*b+c
    logic                   final_sign;
    logic                   sticky_before_add;
    exp_t                   exp_difference;
    exp_t                   exp_product;
    exp_t                   tentative_exp;
    shamt_t                 addend_shamt;
    logic                   eff_sub;
    fma_op_pkg::roundmode_e rnd_mode;
    fp_t                    special_result;
    fma_op_pkg::status_t    special_status;
    logic                   is_special;
  } add_stage_t;

  // Stage 3 to 4
  typedef struct packed {
    logic [PRECISION_BITS:0] final_mant;     // Mantissa plus round bit
    exp_t                    final_exp;
    logic                    sticky;
    logic                    sign;
    fma_op_pkg::roundmode_e  rnd_mode;
    logic                    eff_sub;
    fp_t                     special_result;
    fma_op_pkg::status_t     special_status;
    logic                    is_special;
  } norm_stage_t;

endpackage

// ==== design/fma_lzc.sv ====
`timescale 1ns/1ps

module fma_lzc (
  input  logic [fma_fmt_pkg::LOWER_SUM_WIDTH-1:0] value_i,
  output logic [fma_fmt_pkg::LZC_WIDTH-1:0]       count_o,
  output logic                                    empty_o
);

  logic found;  // Leading one seen so far

  // Scan from the MSB, counting zeros until the first one
  always_comb begin
    count_o = '0;
    found   = 1'b0;
    for (int i = $bits(value_i) - 1; i >= 0; i--) begin
      if (!found && !value_i[i]) begin
        count_o = count_o + 1'b1;
      end else begin
        found = 1'b1;
      end
    end
  end

  assign empty_o = ~|value_i;  // Count is meaningless then

endmodule

// ==== design/fma_normalize.sv ====
`timescale 1ns/1ps

module fma_normalize (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  fma_fmt_pkg::add_stage_t  stage_i,
  input  logic                     valid_i,
  output fma_fmt_pkg::norm_stage_t stage_o,
  output logic                     valid_o
);
  import fma_fmt_pkg::*;

  logic [LZC_WIDTH-1:0]          lzc_count;
  logic                          lzc_empty;
  exp_t                          lzc_count_sgn;
  shamt_t                        norm_shamt;
  exp_t                          norm_exp, final_exp;
  logic [SUM_WIDTH:0]            sum_shifted;   // Carry bit kept for the 1-bit fix
  logic [PRECISION_BITS:0]       final_mant;    // With round bit
  logic [2*PRECISION_BITS+2:0]   sticky_bits;
  logic                          sticky;

  fma_lzc u_lzc (
    .value_i (stage_i.sum[LOWER_SUM_WIDTH-1:0]),
    .count_o (lzc_count),
    .empty_o (lzc_empty)
  );

  assign lzc_count_sgn = exp_t'({1'b0, lzc_count});

  // ------------------------------
  // Large shift
  // ------------------------------
  always_comb begin
    // Product-anchored or cancelling sums need the LZC
    if ((stage_i.exp_difference <= 0) || (stage_i.eff_sub && (stage_i.exp_difference <= 2))) begin
      if ((stage_i.exp_product - lzc_count_sgn + 1 >= 0) && !lzc_empty) begin
        norm_shamt = shamt_t'(PRECISION_BITS + 2 + lzc_count);
        norm_exp   = exp_t'(stage_i.exp_product - lzc_count_sgn + 1);
      end else begin
        norm_shamt = shamt_t'(PRECISION_BITS + 2 + stage_i.exp_product);  // Stop at emin
        norm_exp   = '0;                                                   // Subnormal
      end
    end else begin
      norm_shamt = stage_i.addend_shamt;  // Undo addend alignment
      norm_exp   = stage_i.tentative_exp;
    end
  end

  assign sum_shifted = {1'b0, stage_i.sum} << norm_shamt;

  // ------------------------------
  // Small shift
  // ------------------------------
  always_comb begin
    {final_mant, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                 = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin                 // Overflowed one place
      {final_mant, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                 = exp_t'(norm_exp + 1);
    end else if (!sum_shifted[SUM_WIDTH-1]) begin     // Leading zero left over
      if (norm_exp > 1) begin
        {final_mant, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
        final_exp                 = exp_t'(norm_exp - 1);
      end else begin
        final_exp = '0;
      end
    end
  end

  assign sticky = (|sticky_bits) | stage_i.sticky_before_add;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_o <= 1'b0;
    else          valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    stage_o <= '{final_mant: final_mant, final_exp: final_exp, sticky: sticky,
                 sign: stage_i.final_sign, rnd_mode: stage_i.rnd_mode, eff_sub: stage_i.eff_sub,
                 special_result: stage_i.special_result,
                 special_status: stage_i.special_status, is_special: stage_i.is_special};
  end

endmodule

// ==== design/fma_op_pkg.sv ====
package fma_op_pkg;

  // ------------------------------
  // Operation decode
  // ------------------------------
  // op_mod inverts the addend sign in every case
  typedef enum logic [1:0] {
    FMADD  = 2'd0,  // a*b+c, op_mod gives FMSUB
    FNMSUB = 2'd1,  // -(a*b)+c, op_mod gives FNMADD
    ADD    = 2'd2,  // 1.0*b+c, op_mod gives SUB
    MUL    = 2'd3   // a*b+(-0.0)
  } operation_e;

  // ------------------------------
  // Rounding modes
  // ------------------------------
  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,  // Toward zero
    RDN = 3'd2,  // Toward -inf
    RUP = 3'd3,  // Toward +inf
    RMM = 3'd4   // Nearest, ties away from zero
  } roundmode_e;

  // ------------------------------
  // Status flags
  // ------------------------------
  typedef struct packed {
    logic NV;  // Invalid operation
    logic DZ;  // Divide by zero, never set by an FMA
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // Canonical quiet NaN
  localparam logic [15:0] QNAN = 16'h7E00;

endpackage

// ==== design/fma_operand_prep.sv ====
`timescale 1ns/1ps

module fma_operand_prep (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  fma_fmt_pkg::fp_word_t [2:0]    operands_i,  // A, B, C
  input  fma_op_pkg::roundmode_e         rnd_mode_i,
  input  fma_op_pkg::operation_e         op_i,
  input  logic                           op_mod_i,
  input  logic                           valid_i,
  output fma_fmt_pkg::prep_stage_t       stage_o,
  output logic                           valid_o
);
  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  fp_info_t [2:0] info_raw;
  fp_t            op_a, op_b, op_c;
  fp_info_t       info_a, info_b, info_c;

  for (genvar i = 0; i < 3; i++) begin : g_classify
    fma_classify u_classify (
      .operand_i (operands_i[i]),
      .info_o    (info_raw[i])
    );
  end

  // ------------------------------
  // Operand adjustment
  // ------------------------------
  always_comb begin
    op_a   = operands_i[0];
    op_b   = operands_i[1];
    op_c   = operands_i[2];
    info_a = info_raw[0];
    info_b = info_raw[1];
    info_c = info_raw[2];
    op_c.sign = op_c.sign ^ op_mod_i;  // FMSUB, FNMADD, SUB
    case (op_i)
      FNMSUB: op_a.sign = ~op_a.sign;  // Negate the product
      ADD: begin
        op_a   = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};  // +1.0
        info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin
        op_c   = '{sign: 1'b1, exponent: '0, mantissa: '0};  // -0.0 keeps sign of zero products
        info_c = '{is_zero: 1'b1, default: 1'b0};
      end
      default: ;  // FMADD as is
    endcase
  end

  logic eff_sub, tent_sign, any_nan, any_snan, prod_inf;

  assign tent_sign = op_a.sign ^ op_b.sign;
  assign eff_sub   = tent_sign ^ op_c.sign;  // Product and addend signs differ
  assign any_nan   = info_a.is_nan | info_b.is_nan | info_c.is_nan;
  assign any_snan  = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
  assign prod_inf  = info_a.is_inf | info_b.is_inf;

  // ------------------------------
  // Special cases
  // ------------------------------
  fp_t     special_result;
  status_t special_status;
  logic    is_special;

  always_comb begin
    special_result = QNAN;
    special_status = '0;
    is_special     = 1'b1;
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      special_status.NV = 1'b1;  // inf*0, even with a quiet NaN addend
    end else if (any_nan) begin
      special_status.NV = any_snan;
    end else if (prod_inf) begin
      if (info_c.is_inf && eff_sub) special_status.NV = 1'b1;  // inf-inf stays qNaN
      else special_result = '{sign: tent_sign, exponent: '1, mantissa: '0};
    end else if (info_c.is_inf) begin
      special_result = '{sign: op_c.sign, exponent: '1, mantissa: '0};
    end else begin
      is_special = 1'b0;  // Regular datapath
    end
  end

  // ------------------------------
  // Exponent path
  // ------------------------------
  exp_t   exp_a, exp_b, exp_c, exp_addend, exp_product, exp_diff, tent_exp;
  shamt_t addend_shamt;

  assign exp_a = exp_t'({1'b0, op_a.exponent});
  assign exp_b = exp_t'({1'b0, op_b.exponent});
  assign exp_c = exp_t'({1'b0, op_c.exponent});
  assign exp_addend  = exp_c + exp_t'(!info_c.is_normal);  // Subnormals sit at exponent 1
  assign exp_product = (info_a.is_zero || info_b.is_zero) ? exp_t'(2 - BIAS)  // Minimum exp
                     : exp_t'(exp_a + exp_t'(info_a.is_subnormal) + exp_b
                              + exp_t'(info_b.is_subnormal) - BIAS);
  assign exp_diff = exp_addend - exp_product;
  assign tent_exp = (exp_diff > 0) ? exp_addend : exp_product;

  always_comb begin
    if (exp_diff <= -2 * PRECISION_BITS - 1)
      addend_shamt = shamt_t'(3 * PRECISION_BITS + 4);  // Addend only reaches sticky
    else if (exp_diff <= PRECISION_BITS + 2)
      addend_shamt = shamt_t'(PRECISION_BITS + 3 - exp_diff);
    else
      addend_shamt = '0;  // Product only reaches sticky
  end

  // ------------------------------
  // Product and register
  // ------------------------------
  mant_t                       mant_a, mant_b, mant_c;
  logic [2*PRECISION_BITS-1:0] product;

  assign mant_a  = {info_a.is_normal, op_a.mantissa};
  assign mant_b  = {info_b.is_normal, op_b.mantissa};
  assign mant_c  = {info_c.is_normal, op_c.mantissa};
  assign product = mant_a * mant_b;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) valid_o <= 1'b0;
    else          valid_o <= valid_i;
  end

  always_ff @(posedge clk_i) begin
    stage_o <= '{product: product, addend_mant: mant_c, exp_product: exp_product,
                 exp_difference: exp_diff, tentative_exp: tent_exp,
                 addend_shamt: addend_shamt, eff_sub: eff_sub, tentative_sign: tent_sign,
                 rnd_mode: rnd_mode_i, special_result: special_result,
                 special_status: special_status, is_special: is_special};
  end

endmodule

// ==== design/fma_round.sv ====
`timescale 1ns/1ps

module fma_round (
  input  fma_fmt_pkg::norm_stage_t stage_i,
  input  logic                     valid_i,
  output fma_fmt_pkg::fp_word_t    result_o,
  output fma_op_pkg::status_t      status_o,
  output logic                     valid_o
);
  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  logic                         of_before, of_after, uf_after;
  logic [EXP_BITS-1:0]          pre_exp;
  logic [MAN_BITS-1:0]          pre_man;
  logic [EXP_BITS+MAN_BITS-1:0] pre_abs, rounded_abs;
  logic [1:0]                   rs_bits;        // Round and sticky
  logic                         round_up;
  logic                         exact_zero;
  logic                         rounded_sign;
  status_t                      regular_status;

  // ------------------------------
  // Pre-round assembly
  // ------------------------------
  assign of_before = stage_i.final_exp >= 2 ** EXP_BITS - 1;
  // Saturate to largest finite, RS forced so rounding decides inf or not
  assign pre_exp = of_before ? EXP_BITS'(2 ** EXP_BITS - 2) : stage_i.final_exp[EXP_BITS-1:0];
  assign pre_man = of_before ? '1 : stage_i.final_mant[MAN_BITS:1];
  assign pre_abs = {pre_exp, pre_man};
  assign rs_bits = of_before ? 2'b11 : {stage_i.final_mant[0], stage_i.sticky};

  always_comb begin
    case (stage_i.rnd_mode)
      RNE:     round_up = rs_bits[1] & (rs_bits[0] | pre_abs[0]);  // Ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_bits) & stage_i.sign;
      RUP:     round_up = (|rs_bits) & ~stage_i.sign;
      RMM:     round_up = rs_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  // Carry into the exponent is the correct renormalization
  assign rounded_abs = pre_abs + round_up;
  assign exact_zero  = (pre_abs == '0) && (rs_bits == 2'b00);
  // Exact cancellation is +0, -0 only under RDN
  assign rounded_sign = (exact_zero && stage_i.eff_sub) ? (stage_i.rnd_mode == RDN)
                                                        : stage_i.sign;

  // ------------------------------
  // Flags and selection
  // ------------------------------
  assign uf_after = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0);
  assign of_after = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);

  assign regular_status.NV = 1'b0;
  assign regular_status.DZ = 1'b0;
  assign regular_status.OF = of_before | of_after;
  assign regular_status.NX = (|rs_bits) | of_before | of_after;
  assign regular_status.UF = uf_after & regular_status.NX;  // Tininess after rounding

  assign result_o = stage_i.is_special ? stage_i.special_result : {rounded_sign, rounded_abs};
  assign status_o = stage_i.is_special ? stage_i.special_status : regular_status;
  assign valid_o  = valid_i;

endmodule

// ==== design/fma_top.sv ====
`timescale 1ns/1ps

module fma_top (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  fma_fmt_pkg::fp_word_t [2:0] operands_i,
  input  fma_op_pkg::roundmode_e      rnd_mode_i,
  input  fma_op_pkg::operation_e      op_i,
  input  logic                        op_mod_i,
  input  logic                        in_valid_i,
  output fma_fmt_pkg::fp_word_t       result_o,
  output fma_op_pkg::status_t         status_o,
  output logic                        out_valid_o
);
  import fma_fmt_pkg::*;

  prep_stage_t stage_1;
  add_stage_t  stage_2;
  norm_stage_t stage_3;
  logic        valid_1, valid_2, valid_3;

  fma_operand_prep u_prep (  // Decode, specials, product
    .clk_i, .rst_n_i, .operands_i, .rnd_mode_i, .op_i, .op_mod_i,
    .valid_i (in_valid_i),
    .stage_o (stage_1),
    .valid_o (valid_1)
  );

  fma_align_add u_add (  // Alignment and wide add
    .clk_i, .rst_n_i,
    .stage_i (stage_1), .valid_i (valid_1),
    .stage_o (stage_2), .valid_o (valid_2)
  );

  fma_normalize u_norm (
    .clk_i, .rst_n_i,
    .stage_i (stage_2), .valid_i (valid_2),
    .stage_o (stage_3), .valid_o (valid_3)
  );

  fma_round u_round (  // Combinational to the outputs
    .stage_i  (stage_3),
    .valid_i  (valid_3),
    .result_o,
    .status_o,
    .valid_o  (out_valid_o)
  );

endmodule

// ==== files.f ====
design/fma_op_pkg.sv
design/fma_fmt_pkg.sv
design/fma_classify.sv
design/fma_lzc.sv
design/fma_operand_prep.sv
design/fma_align_add.sv
design/fma_normalize.sv
design/fma_round.sv
design/fma_top.sv
verification/fma_checker.sv
verification/fma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module fma_tb -o fma_sim
output="$(./obj_dir/fma_sim)"
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// ==== verification/fma_checker.sv ====
`timescale 1ns/1ps

module fma_checker (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  fma_fmt_pkg::fp_word_t [2:0] operands_i,
  input  fma_op_pkg::roundmode_e      rnd_mode_i,
  input  fma_op_pkg::operation_e      op_i,
  input  logic                        op_mod_i,
  input  logic                        in_valid_i,
  input  fma_fmt_pkg::fp_word_t       result_i,
  input  fma_op_pkg::status_t         status_i,
  input  logic                        out_valid_i,
  output int                          value_errors_o,
  output int                          other_errors_o,
  output int                          pending_o
);
  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  logic [20:0] expected_q[$];  // {result, status}
  logic [20:0] expected;
  logic [2:0]  valid_hist;     // in_valid delayed by 1..3 edges
  int          value_errors = 0;
  int          other_errors = 0;
  int          pending = 0;

  assign value_errors_o = value_errors;
  assign other_errors_o = other_errors;
  assign pending_o      = pending;

  // ------------------------------
  // Operand classes
  // ------------------------------
  function automatic logic is_zero(input fp_word_t w);
    return w[14:0] == 15'd0;
  endfunction

  function automatic logic is_inf(input fp_word_t w);
    return w[14:10] == 5'h1F && w[9:0] == 10'd0;
  endfunction

  function automatic logic is_nan(input fp_word_t w);
    return w[14:10] == 5'h1F && w[9:0] != 10'd0;
  endfunction

  // Magnitude in units of 2^-24
  function automatic logic [95:0] magnitude(input fp_word_t w);
    logic [10:0] sig;
    int          e;
    sig = {(w[14:10] != 5'd0), w[9:0]};
    e   = (w[14:10] == 5'd0) ? 1 : int'(w[14:10]);
    return 96'(sig) << (e - 1);
  endfunction

  // ------------------------------
  // Rounding of an exact nonzero value in units of 2^-48
  // ------------------------------
  function automatic logic [20:0] round_exact(input logic sign, input logic [95:0] mag,
                                              input roundmode_e rm);
    int          msb, s, enc;
    logic [95:0] kept, rem, half;
    logic        up, inexact, to_inf;
    msb = 0;
    for (int i = 0; i < 96; i++) if (mag[i]) msb = i;
    s       = (msb - 10 > 24) ? msb - 10 : 24;  // ulp is never below 2^-24
    kept    = mag >> s;
    rem     = mag & ((96'd1 << s) - 96'd1);
    half    = 96'd1 << (s - 1);
    inexact = (rem != 96'd0);
    case (rm)
      RNE:     up = (rem > half) || (rem == half && kept[0]);
      RDN:     up = inexact && sign;
      RUP:     up = inexact && !sign;
      RMM:     up = (rem >= half);
      default: up = 1'b0;
    endcase
    // Exponent field and mantissa in one count so a carry renormalizes
    enc = ((s - 24) << 10) + int'(kept[11:0]) + int'(up);
    if (enc >= 32'h7C00) begin
      to_inf = (rm == RNE) || (rm == RMM) || (rm == RDN && sign) || (rm == RUP && !sign);
      return {sign, to_inf ? 15'h7C00 : 15'h7BFF, 5'b00101};  // OF and NX
    end
    return {sign, 15'(enc), 3'b000, (enc < 1024) && inexact, inexact};
  endfunction

  // Expected {result, status} for one operation
  function automatic logic [20:0] expect_fma(input fp_word_t [2:0] ops, input operation_e op,
                                             input logic op_mod, input roundmode_e rm);
    fp_word_t    a, b, c;
    logic        sp, sc, sign;
    logic [95:0] prod, addend, total;
    a = ops[0];
    b = ops[1];
    c = ops[2];
    c[15] = c[15] ^ op_mod;
    if (op == FNMSUB) a[15] = ~a[15];
    if (op == ADD) a = 16'h3C00;  // +1.0
    if (op == MUL) c = 16'h8000;  // -0.0
    sp = a[15] ^ b[15];
    sc = c[15];
    if ((is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b))) return {QNAN, 5'b10000};
    if (is_nan(a) || is_nan(b) || is_nan(c))
      return {QNAN, (is_nan(a) && !a[9]) || (is_nan(b) && !b[9]) || (is_nan(c) && !c[9]), 4'b0};
    if (is_inf(a) || is_inf(b)) begin
      if (is_inf(c) && sp != sc) return {QNAN, 5'b10000};  // inf - inf
      return {sp, 15'h7C00, 5'b0};
    end
    if (is_inf(c)) return {sc, 15'h7C00, 5'b0};
    prod   = magnitude(a) * magnitude(b);
    addend = magnitude(c) << 24;
    if (sp == sc) begin
      total = prod + addend;
      sign  = sp;
    end else if (prod >= addend) begin
      total = prod - addend;
      sign  = sp;
    end else begin
      total = addend - prod;
      sign  = sc;
    end
    // Exact zero from opposite signs is +0 except under RDN
    if (total == 96'd0) return {(sp == sc) ? sp : (rm == RDN), 15'd0, 5'b0};
    return round_exact(sign, total, rm);
  endfunction

  // ------------------------------
  // Monitor sampled on the rising edge
  // ------------------------------
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_hist = '0;
    end else begin
      if (out_valid_i !== valid_hist[2]) begin  // Exactly three edges after the input
        other_errors++;
        $display("FAIL t=%0t out_valid_o expected %b got %b", $time, valid_hist[2], out_valid_i);
      end
      if (out_valid_i === 1'b1) begin
        if (expected_q.size() == 0) begin
          other_errors++;
          $display("ERROR at %0t: an output appeared with no operation pending", $time);
        end else begin
          expected = expected_q.pop_front();
          if (result_i !== expected[20:5]) begin
            value_errors++;
            $display("FAIL t=%0t result_o expected %h got %h", $time, expected[20:5], result_i);
          end
          if (status_i !== expected[4:0]) begin
            value_errors++;
            $display("FAIL t=%0t status_o expected %b got %b", $time, expected[4:0], status_i);
          end
        end
      end
      if (in_valid_i) expected_q.push_back(expect_fma(operands_i, op_i, op_mod_i, rnd_mode_i));
      valid_hist = {valid_hist[1:0], in_valid_i};
    end
    pending = expected_q.size();
  end

endmodule

// ==== verification/fma_tb.sv ====
`timescale 1ns/1ps

module fma_tb;
  import fma_fmt_pkg::*;
  import fma_op_pkg::*;

  localparam int NUM_OPS      = 2000;
  localparam int STIM_LIMIT   = 20 * NUM_OPS;  // Cycles allowed for issuing
  localparam int DRAIN_CYCLES = 20;

  logic            clk;
  logic            rst_n;
  fp_word_t [2:0]  operands;  // C, B, A
  roundmode_e      rnd_mode;
  operation_e      op;
  logic            op_mod;
  logic            in_valid;
  fp_word_t        result;
  status_t         status;
  logic            out_valid;
  int              value_errors, other_errors, pending;
  int              stim_errors;
  logic [31:0]     lfsr_state;

  fma_top dut_i (
    .clk_i (clk), .rst_n_i (rst_n), .operands_i (operands), .rnd_mode_i (rnd_mode),
    .op_i (op), .op_mod_i (op_mod), .in_valid_i (in_valid),
    .result_o (result), .status_o (status), .out_valid_o (out_valid)
  );

  fma_checker check_i (
    .clk_i (clk), .rst_n_i (rst_n), .operands_i (operands), .rnd_mode_i (rnd_mode),
    .op_i (op), .op_mod_i (op_mod), .in_valid_i (in_valid),
    .result_i (result), .status_i (status), .out_valid_i (out_valid),
    .value_errors_o (value_errors), .other_errors_o (other_errors), .pending_o (pending)
  );

  always #20 clk = ~clk;  // 40 ns period

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);  // Galois form
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  // Class from 3 bits then random fields
  function automatic fp_word_t make_operand();
    logic [2:0] cls;
    logic       sign;
    logic [4:0] e;
    logic [9:0] m;
    cls  = 3'(take_bits(3));
    sign = 1'(take_bits(1));
    e    = 5'(take_bits(5));
    m    = 10'(take_bits(10));
    case (cls)
      3'd0: return {sign, 15'd0};                                       // Zero
      3'd1: return {sign, 5'd0, (m == 10'd0) ? 10'd1 : m};              // Subnormal
      3'd2: return {sign, 5'(5'd14 + 5'(e[1:0])), m};                   // Near bias
      3'd4: return {sign, 5'h1F, 10'd0};                                // Infinity
      3'd5: return {sign, 5'h1F, 1'b1, m[8:0]};                         // Quiet NaN
      3'd6: return {sign, 5'h1F, 1'b0, (m[8:0] == 9'd0) ? 9'd1 : m[8:0]};  // Signalling
      default: return {sign, (e == 5'd0) ? 5'd1 : (e == 5'h1F) ? 5'd30 : e, m};
    endcase
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin
    fp_word_t a, b, c;
    int       sent, cycle, drain, ce;
    clk      = 1'b0;
    rst_n    = 1'b0;
    operands = '0;
    rnd_mode = RNE;
    op       = FMADD;
    op_mod   = 1'b0;
    in_valid = 1'b0;
    lfsr_state = 32'h2bbf;
    stim_errors = 0;
    sent = 0;
    cycle = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (sent < NUM_OPS && cycle < STIM_LIMIT) begin
      @(posedge clk);
      cycle++;
      if (take_bits(2) != 32'd0) begin  // Gaps one time in four
        a = make_operand();
        b = make_operand();
        c = make_operand();
        // Addend at the product exponent to provoke cancellation
        if (take_bits(2) == 32'd0 && a[14:10] != 5'd0 && a[14:10] != 5'h1F &&
            b[14:10] != 5'd0 && b[14:10] != 5'h1F && c[14:10] != 5'd0 && c[14:10] != 5'h1F) begin
          ce = int'(a[14:10]) + int'(b[14:10]) - BIAS;
          if (ce >= 1 && ce <= 30) c[14:10] = 5'(ce);
        end
        operands <= {c, b, a};
        rnd_mode <= roundmode_e'(3'(take_bits(3) % 5));
        op       <= operation_e'(take_bits(2));
        op_mod   <= 1'(take_bits(1));
        in_valid <= 1'b1;
        sent++;
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    if (sent < NUM_OPS) begin
      stim_errors++;
      $display("ERROR: only %0d of %0d operations issued before the stimulus timeout",
               sent, NUM_OPS);
    end
    // Drain sampled away from the rising edge
    drain = 0;
    @(negedge clk);
    while (pending != 0 && drain < DRAIN_CYCLES) begin
      @(negedge clk);
      drain++;
    end
    if (pending != 0) begin
      stim_errors++;
      $display("ERROR: %0d operations never came out before the drain timeout", pending);
    end
    $display("Errors: value %0d, protocol %0d, testbench %0d",
             value_errors, other_errors, stim_errors);
    if (value_errors + other_errors + stim_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
